// ==== design/mem_params.svh ====
//~~~~~~~~~~~~~~~~~~~~
// widths, opcode fields, L1.5 request and
// return codes, message size codes
//~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// datapath
`define XLEN            32
`define L15_DATA_W      64      // one half of a response, also the request data
`define L15_TYPE_W      4       // rqtype and returntype
`define OP_W            4
`define LANE_W          4

// opcode fields
`define OP_STORE_BIT    3
`define OP_SIGNED_BIT   0
`define WIDTH_WORD      2'b11
`define WIDTH_HALF      2'b01
`define WIDTH_BYTE      2'b10

// request types
`define RQ_LOAD         4'b0000
`define RQ_STORE        4'b0001

// return types
`define RET_LOAD        4'b0000
`define RET_ST_ACK      4'b0100
`define RET_INT         4'b0111

// message data size
`define SIZE_W          3
`define SIZE_0B         3'b000
`define SIZE_1B         3'b001
`define SIZE_2B         3'b010
`define SIZE_4B         3'b011

`endif

// ==== design/mem_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// opcode, stage payload and size types
//~~~~~~~~~~~~~~~~~~~~
`include "mem_params.svh"

package mem_pkg;

    // opcode encoding
    //   [3]   store 1, load 0
    //   [2:1] word 11, half 01, byte 10
    //   [0]   signed load
    //   all zero is no memory op
    //
    //   SW 1111  SH 1011  SB 1101
    //   LW 0111  LH 0011  LHU 0010  LB 0101  LBU 0100
    typedef logic [`OP_W-1:0] mem_op_t;

    // L1.5 message size code
    typedef logic [`SIZE_W-1:0] l15_size_t;

    // stage 5 payload, straight from execute
    typedef struct packed {
        mem_op_t           op;
        logic [`XLEN-1:0]  base;     // op_a
        logic [`XLEN-1:0]  opnd;     // store data or load offset
        logic [`XLEN-1:0]  s_imm;    // store offset
    } exec_req_t;

    // stage 6 payload, decoded controls for the cache port
    typedef struct packed {
        mem_op_t             op;
        logic [`XLEN-1:0]    addr;
        logic [`XLEN-1:0]    wdata;
        logic [`LANE_W-1:0]  lanes;    // byte lane per address bits 1:0
        logic                rd;
        logic                wr;
        logic                ld_mis;
        logic                st_mis;
    } mem_ctrl_t;

endpackage

// ==== design/mem_stage_reg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// pipeline register, typed payload
// with advance enable
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_stage_reg
    import mem_pkg::*;
#(
    parameter type payload_t = exec_req_t
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     advance,
    input  payload_t d,
    output payload_t q
);

    // cleared stage holds opcode zero, so no op after reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            q <= '0;
        end else if (advance) begin
            q <= d;
        end
    end

endmodule

// ==== design/mem_addr_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~
// stage 5 decode: effective address,
// misalignment, byte lanes, access kind
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_addr_gen
    import mem_pkg::*;
(
    input  exec_req_t req,
    output mem_ctrl_t ctrl
);

    logic [`XLEN-1:0]    addr;
    logic [1:0]          width;
    logic                is_store;
    logic                legal;      // op carries a known width
    logic                mis;
    logic [`LANE_W-1:0]  lanes;

    assign is_store = req.op[`OP_STORE_BIT];
    assign width    = req.op[2:1];
    assign legal    = (width != 2'b00);

    // stores add the S immediate, loads the I offset in op_b
    assign addr = is_store ? (req.base + req.s_imm) : (req.base + req.opnd);

    // half on odd byte, word off a 4-byte boundary
    assign mis = (req.op[1] & addr[0]) | (req.op[2] & req.op[1] & addr[1]);

    always_comb begin
        lanes = '0;
        if (legal && !mis) begin
            case (width)
                `WIDTH_BYTE: lanes = 4'b0001 << addr[1:0];
                `WIDTH_HALF: lanes = addr[1] ? 4'b1100 : 4'b0011;
                `WIDTH_WORD: lanes = 4'b1111;
                default:     lanes = '0;
            endcase
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.op     = req.op;
        ctrl.addr   = addr;
        ctrl.wdata  = req.opnd;             // store source
        ctrl.lanes  = lanes;
        ctrl.rd     = legal & ~mis & ~is_store;
        ctrl.wr     = legal & ~mis & is_store;
        ctrl.ld_mis = mis & ~is_store;
        ctrl.st_mis = mis & is_store;       // store side exception
    end

endmodule

// ==== design/l15_req_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~
// L1.5 request/response FSM with endian
// swap, size encoding, return matching
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module l15_req_ctrl
    import mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  mem_ctrl_t               ctrl,

    // request side
    output logic [`L15_TYPE_W-1:0]  mem_l15_rqtype,
    output l15_size_t               mem_l15_size,
    output logic [`XLEN-1:0]        mem_l15_address,
    output logic [`L15_DATA_W-1:0]  mem_l15_data,
    output logic                    mem_l15_val,
    input  logic                    l15_mem_header_ack,

    // response side
    input  logic                    l15_mem_val,
    input  logic [`L15_TYPE_W-1:0]  l15_mem_returntype,
    output logic                    mem_l15_req_ack,

    // to the pipeline and aligner
    output logic                    req_fire,
    output mem_op_t                 pend_op,
    output logic [`XLEN-1:0]        pend_addr,
    output logic                    mem_done
);

    typedef enum logic {
        st_idle,
        st_wait
    } state_t;

    state_t           state;
    logic             access;
    logic             ret_match;
    logic             resp_ok;
    logic [`XLEN-1:0] wdata_be;

    assign access = ctrl.rd | ctrl.wr;

    // val is a level, held until the header is taken
    assign mem_l15_val = (state == st_idle) & access;
    assign req_fire    = mem_l15_val & l15_mem_header_ack;

    // cache is big-endian
    assign wdata_be = {ctrl.wdata[7:0], ctrl.wdata[15:8],
                       ctrl.wdata[23:16], ctrl.wdata[31:24]};

    assign mem_l15_rqtype  = ctrl.wr ? `RQ_STORE : `RQ_LOAD;
    assign mem_l15_address = ctrl.addr;
    assign mem_l15_data    = {wdata_be, wdata_be};  // same word in both halves

    always_comb begin
        case (ctrl.lanes)
            4'b1111:                            mem_l15_size = `SIZE_4B;
            4'b0011, 4'b1100:                   mem_l15_size = `SIZE_2B;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: mem_l15_size = `SIZE_1B;
            default:                            mem_l15_size = `SIZE_0B;
        endcase
    end

    // every response gets acked, only the matching one finishes the op
    assign mem_l15_req_ack = l15_mem_val;
    assign ret_match = pend_op[`OP_STORE_BIT] ? (l15_mem_returntype == `RET_ST_ACK)
                                              : (l15_mem_returntype == `RET_LOAD);
    assign resp_ok   = (state == st_wait) & l15_mem_val & ret_match;
    assign mem_done  = resp_ok;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= st_idle;
            pend_op   <= '0;
            pend_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_fire) begin
                        state     <= st_wait;
                        pend_op   <= ctrl.op;      // kept for the aligner
                        pend_addr <= ctrl.addr;
                    end
                end
                st_wait: begin
                    if (resp_ok) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== design/load_align.sv ====
//~~~~~~~~~~~~~~~~~~~~
// response word select, byte swap,
// load sign/zero extension
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module load_align
    import mem_pkg::*;
(
    input  mem_op_t                 pend_op,
    input  logic [`XLEN-1:0]        pend_addr,
    input  logic [`L15_DATA_W-1:0]  l15_mem_data_0,
    input  logic [`L15_DATA_W-1:0]  l15_mem_data_1,
    output logic [`XLEN-1:0]        mem_out
);

    logic [`XLEN-1:0] word_be;
    logic [`XLEN-1:0] word_le;
    logic [7:0]       byte_sel;
    logic [15:0]      half_sel;
    logic             sgn;

    // 128-bit line, most significant quarter at the lowest address
    always_comb begin
        case (pend_addr[3:2])
            2'b00:   word_be = l15_mem_data_0[63:32];
            2'b01:   word_be = l15_mem_data_0[31:0];
            2'b10:   word_be = l15_mem_data_1[63:32];
            default: word_be = l15_mem_data_1[31:0];
        endcase
    end

    assign word_le = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};

    assign byte_sel = word_le[pend_addr[1:0]*8 +: 8];
    assign half_sel = pend_addr[1] ? word_le[31:16] : word_le[15:0];
    assign sgn      = pend_op[`OP_SIGNED_BIT];

    always_comb begin
        case (pend_op[2:1])
            `WIDTH_WORD: mem_out = word_le;
            `WIDTH_HALF: mem_out = {{16{sgn & half_sel[15]}}, half_sel};   // lh / lhu
            `WIDTH_BYTE: mem_out = {{24{sgn & byte_sel[7]}}, byte_sel};    // lb / lbu
            default:     mem_out = '0;
        endcase
    end

endmodule

// ==== design/mem_wrap.sv ====
//~~~~~~~~~~~~~~~~~~~~
// memory stage top: stage 5/6 registers,
// decode, L1.5 controller, load aligner
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_wrap
    import mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,

    // from execute
    input  mem_op_t                 mem_op,
    input  logic [`XLEN-1:0]        op_a,
    input  logic [`XLEN-1:0]        op_b,
    input  logic [`XLEN-1:0]        s_imm,

    // to the core
    output logic                    mem_busy,
    output logic [`XLEN-1:0]        mem_out,
    output logic                    mem_done,
    output logic                    ld_misaligned,
    output logic                    st_misaligned,

    // L1.5 request
    output logic [`L15_TYPE_W-1:0]  mem_l15_rqtype,
    output l15_size_t               mem_l15_size,
    output logic [`XLEN-1:0]        mem_l15_address,
    output logic [`L15_DATA_W-1:0]  mem_l15_data,
    output logic                    mem_l15_val,
    input  logic                    l15_mem_header_ack,

    // L1.5 response
    input  logic [`L15_DATA_W-1:0]  l15_mem_data_0,
    input  logic [`L15_DATA_W-1:0]  l15_mem_data_1,
    input  logic [`L15_TYPE_W-1:0]  l15_mem_returntype,
    input  logic                    l15_mem_val,
    output logic                    mem_l15_req_ack
);

    exec_req_t        exec_in;
    exec_req_t        s5_q;
    mem_ctrl_t        s5_ctrl;
    mem_ctrl_t        s6_q;
    logic             advance;
    logic             req_fire;
    mem_op_t          pend_op;
    logic [`XLEN-1:0] pend_addr;

    assign exec_in = '{op: mem_op, base: op_a, opnd: op_b, s_imm: s_imm};

    // both stages move when stage 6 is empty or its request is taken
    assign advance  = ~(s6_q.rd | s6_q.wr) | req_fire;
    assign mem_busy = ~advance;

    // flags live for the single cycle the op sits in stage 6
    assign ld_misaligned = s6_q.ld_mis;
    assign st_misaligned = s6_q.st_mis;

    mem_stage_reg #(.payload_t(exec_req_t)) u_stage5 (
        .clk     (clk),
        .nrst    (nrst),
        .advance (advance),
        .d       (exec_in),
        .q       (s5_q)
    );

    mem_addr_gen u_addr_gen (
        .req  (s5_q),
        .ctrl (s5_ctrl)
    );

    mem_stage_reg #(.payload_t(mem_ctrl_t)) u_stage6 (
        .clk     (clk),
        .nrst    (nrst),
        .advance (advance),
        .d       (s5_ctrl),
        .q       (s6_q)
    );

    l15_req_ctrl u_req_ctrl (
        .clk                (clk),
        .nrst               (nrst),
        .ctrl               (s6_q),
        .mem_l15_rqtype     (mem_l15_rqtype),
        .mem_l15_size       (mem_l15_size),
        .mem_l15_address    (mem_l15_address),
        .mem_l15_data       (mem_l15_data),
        .mem_l15_val        (mem_l15_val),
        .l15_mem_header_ack (l15_mem_header_ack),
        .l15_mem_val        (l15_mem_val),
        .l15_mem_returntype (l15_mem_returntype),
        .mem_l15_req_ack    (mem_l15_req_ack),
        .req_fire           (req_fire),
        .pend_op            (pend_op),
        .pend_addr          (pend_addr),
        .mem_done           (mem_done)
    );

    load_align u_load_align (
        .pend_op        (pend_op),
        .pend_addr      (pend_addr),
        .l15_mem_data_0 (l15_mem_data_0),
        .l15_mem_data_1 (l15_mem_data_1),
        .mem_out        (mem_out)
    );

endmodule

// ==== tb/mem_wrap_assert.sv ====
//~~~~~~~~~~~~~~~~~~~~
// L1.5 port protocol assertions,
// bound into mem_wrap
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_wrap_assert (
    input logic                    clk,
    input logic                    nrst,
    input logic                    mem_l15_val,
    input logic                    l15_mem_header_ack,
    input logic [`L15_TYPE_W-1:0]  mem_l15_rqtype,
    input logic [`SIZE_W-1:0]      mem_l15_size,
    input logic [`XLEN-1:0]        mem_l15_address,
    input logic [`L15_DATA_W-1:0]  mem_l15_data,
    input logic                    mem_done
);

    logic outstanding;      // header taken, matching return not yet seen

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            outstanding <= 1'b0;
        end else if (mem_l15_val && l15_mem_header_ack) begin
            outstanding <= 1'b1;
        end else if (mem_done) begin
            outstanding <= 1'b0;
        end
    end

    // header not taken, so the request must hold still
    a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (mem_l15_val && !l15_mem_header_ack) |=> (mem_l15_val && $stable(mem_l15_rqtype)
            && $stable(mem_l15_size) && $stable(mem_l15_address) && $stable(mem_l15_data)))
        else $error("request changed while header_ack was low");

    a_done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        mem_done |=> !mem_done)
        else $error("mem_done high two cycles in a row");

    // one outstanding request at a time
    a_no_val_wait: assert property (@(posedge clk) disable iff (!nrst)
        outstanding |-> !mem_l15_val)
        else $error("request valid raised while waiting for a response");

endmodule

bind mem_wrap mem_wrap_assert u_mem_wrap_assert (
    .clk                (clk),
    .nrst               (nrst),
    .mem_l15_val        (mem_l15_val),
    .l15_mem_header_ack (l15_mem_header_ack),
    .mem_l15_rqtype     (mem_l15_rqtype),
    .mem_l15_size       (mem_l15_size),
    .mem_l15_address    (mem_l15_address),
    .mem_l15_data       (mem_l15_data),
    .mem_done           (mem_done)
);

// ==== tb/mem_wrap_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~
// mem_wrap testbench: L1.5 model,
// stimulus table, checks, summary
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_params.svh"

module mem_wrap_tb
    import mem_pkg::*;
;
    localparam int NROWS = 14;
    localparam int ROW_CYC = 20;
    localparam int LIMIT = NROWS * ROW_CYC;

    logic clk, nrst;
    mem_op_t mem_op;
    logic [31:0] op_a, op_b, s_imm;
    logic mem_busy, mem_done, ld_misaligned, st_misaligned;
    logic [31:0] mem_out, mem_l15_address;
    logic [3:0] mem_l15_rqtype, l15_mem_returntype;
    l15_size_t mem_l15_size;
    logic [63:0] mem_l15_data, l15_mem_data_0, l15_mem_data_1;
    logic mem_l15_val, l15_mem_header_ack, l15_mem_val, mem_l15_req_ack;

    // stimulus and expected-value table
    string       names [NROWS];
    logic [3:0]  ops [NROWS];
    logic [31:0] bases [NROWS], opnds [NROWS], imms [NROWS];
    int          kinds [NROWS];          // 0 access, 1 load misaligned, 2 store misaligned
    bit          int_first [NROWS];      // interrupt return before the real one
    int          holds [NROWS];          // header_ack hold-off, 0 picks at random
    logic [3:0]  exp_rq [NROWS];
    logic [2:0]  exp_size [NROWS];
    logic [31:0] exp_addr [NROWS], exp_out [NROWS];
    logic [63:0] exp_data [NROWS];
    logic [127:0] resps [NROWS];

    int row_err [NROWS];
    int errors, done_cnt, access_cnt, cycles;
    int pending [$];                     // rows whose request is still to come
    logic [31:0] seed_dummy;

    mem_wrap u_mem_wrap (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic set_row(input int i, input string n, input logic [3:0] op,
            input logic [31:0] b, input logic [31:0] o, input logic [31:0] im,
            input int k, input bit intf, input int h, input logic [3:0] rq,
            input logic [2:0] sz, input logic [31:0] ad, input logic [63:0] dat,
            input logic [127:0] rsp, input logic [31:0] out);
        names[i] = n;
        ops[i] = op;
        bases[i] = b;
        opnds[i] = o;
        imms[i] = im;
        kinds[i] = k;
        int_first[i] = intf;
        holds[i] = h;
        exp_rq[i] = rq;
        exp_size[i] = sz;
        exp_addr[i] = ad;
        exp_data[i] = dat;
        resps[i] = rsp;
        exp_out[i] = out;
        row_err[i] = 0;
    endtask

    task automatic load_table();
        logic [127:0] r;
        r = 128'h0011_2233_4455_6677_8899_AABB_CCDD_EEFF;
        set_row(0, "sw", 4'hF, 32'h1000, 32'h1122_3344, 32'h8, 0, 0, 0,
                `RQ_STORE, `SIZE_4B, 32'h1008, 64'h44332211_44332211, r, 0);
        set_row(1, "sh", 4'hB, 32'h2000, 32'hAABB_CCDD, 32'h6, 0, 0, 0,
                `RQ_STORE, `SIZE_2B, 32'h2006, 64'hDDCCBBAA_DDCCBBAA, r, 0);
        set_row(2, "sb", 4'hD, 32'h3000, 32'h1234_56EE, 32'h3, 0, 0, 0,
                `RQ_STORE, `SIZE_1B, 32'h3003, 64'hEE563412_EE563412, r, 0);
        set_row(3, "lw", 4'h7, 32'h4000, 32'h4, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_4B, 32'h4004, 0, r, 32'h7766_5544);
        set_row(4, "lh", 4'h3, 32'h4000, 32'hA, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_2B, 32'h400A, 0, r, 32'hFFFF_BBAA);
        set_row(5, "lhu", 4'h2, 32'h4000, 32'h8, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_2B, 32'h4008, 0, r, 32'h0000_9988);
        set_row(6, "lb_neg", 4'h5, 32'h4000, 32'hD, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_1B, 32'h400D, 0, r, 32'hFFFF_FFDD);
        set_row(7, "lbu", 4'h4, 32'h4000, 32'h2, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_1B, 32'h4002, 0, r, 32'h0000_0022);
        set_row(8, "lb_pos", 4'h5, 32'h4000, 32'h1, 32'h0, 0, 0, 0,
                `RQ_LOAD, `SIZE_1B, 32'h4001, 0, r, 32'h0000_0011);
        set_row(9, "lh_mis", 4'h3, 32'h5000, 32'h3, 32'h0, 1, 0, 0,
                0, 0, 0, 0, r, 0);
        set_row(10, "sw_mis", 4'hF, 32'h5000, 32'h0, 32'h2, 2, 0, 0,
                0, 0, 0, 0, r, 0);
        set_row(11, "lw_int", 4'h7, 32'h6000, 32'hC, 32'h0, 0, 1, 0,
                `RQ_LOAD, `SIZE_4B, 32'h600C, 0, r, 32'hFFEE_DDCC);
        set_row(12, "sw_b2b", 4'hF, 32'h7000, 32'hCAFE_F00D, 32'h0, 0, 0, 3,
                `RQ_STORE, `SIZE_4B, 32'h7000, 64'h0DF0FECA_0DF0FECA, r, 0);
        set_row(13, "lw_b2b", 4'h7, 32'h7000, 32'h4, 32'h0, 0, 0, 3, `RQ_LOAD,
                `SIZE_4B, 32'h7004, 0, 128'hDEADBEEF_01020304_A0B0C0D0_0A0B0C0D,
                32'h0403_0201);
    endtask

    task automatic note_error(input int idx);
        errors++;
        if (idx >= 0) row_err[idx]++;
    endtask

    task automatic check_value(input int idx, input string what,
            input logic [63:0] exp, input logic [63:0] act);
        string tn;
        tn = (idx < 0) ? "reset" : names[idx];
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", tn, what, exp, act);
            note_error(idx);
        end
    endtask

    task automatic check_request(input int idx);
        check_value(idx, "rqtype", exp_rq[idx], mem_l15_rqtype);
        check_value(idx, "size", exp_size[idx], mem_l15_size);
        check_value(idx, "address", exp_addr[idx], mem_l15_address);
        if (exp_rq[idx] == `RQ_STORE) check_value(idx, "data", exp_data[idx], mem_l15_data);
    endtask

    // inputs stay on the port until stage 5 takes them
    task automatic hold_until_taken();
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            #5;
            taken = !mem_busy;      // settled, header_ack only moves on negedge
            @(negedge clk);
        end
    endtask

    // L1.5 model, serves one request at a time in order
    initial begin
        int idx;
        int hold;
        int lat;
        seed_dummy = $urandom(32'h727d);
        l15_mem_header_ack = 1'b0;
        l15_mem_val = 1'b0;
        l15_mem_returntype = '0;
        l15_mem_data_0 = '0;
        l15_mem_data_1 = '0;
        forever begin
            @(negedge clk);
            if (mem_l15_val && pending.size() == 0) begin
                $display("request seen with no access outstanding");
                $display("*** TEST FAILED ***");
                $finish;
            end else if (mem_l15_val) begin
                idx = pending.pop_front();
                hold = (holds[idx] != 0) ? holds[idx] : $urandom_range(0, 3);
                check_request(idx);
                repeat (hold) begin
                    check_value(idx, "mem_busy", 1, mem_busy);
                    @(negedge clk);
                    check_request(idx);     // fields held under back-pressure
                end
                l15_mem_header_ack = 1'b1;
                @(negedge clk);
                l15_mem_header_ack = 1'b0;
                lat = $urandom_range(1, 4);
                repeat (lat - 1) @(negedge clk);
                {l15_mem_data_0, l15_mem_data_1} = resps[idx];
                if (int_first[idx]) begin
                    l15_mem_val = 1'b1;
                    l15_mem_returntype = `RET_INT;
                    #5;
                    check_value(idx, "int mem_done", 0, mem_done);
                    check_value(idx, "int req_ack", 1, mem_l15_req_ack);
                    @(negedge clk);
                    l15_mem_val = 1'b0;
                    @(negedge clk);
                end
                l15_mem_val = 1'b1;
                l15_mem_returntype = (exp_rq[idx] == `RQ_STORE) ? `RET_ST_ACK : `RET_LOAD;
                #5;
                check_value(idx, "mem_done", 1, mem_done);
                if (exp_rq[idx] == `RQ_LOAD) check_value(idx, "mem_out", exp_out[idx], mem_out);
                $display("test %-8s %s", names[idx], (row_err[idx] == 0) ? "ok" : "FAILED");
                @(negedge clk);
                l15_mem_val = 1'b0;
                done_cnt++;
            end
        end
    end

    initial begin
        cycles = 0;
        @(posedge nrst);
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, operations did not complete", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int c;
        int passed;
        int reset_err;
        errors = 0;
        done_cnt = 0;
        access_cnt = 0;
        nrst = 1'b0;
        mem_op = '0;
        op_a = '0;
        op_b = '0;
        s_imm = '0;
        load_table();
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_value(-1, "mem_l15_val", 0, mem_l15_val);
        check_value(-1, "mem_done", 0, mem_done);
        check_value(-1, "mem_busy", 0, mem_busy);
        check_value(-1, "ld_misaligned", 0, ld_misaligned);
        check_value(-1, "st_misaligned", 0, st_misaligned);
        check_value(-1, "mem_l15_req_ack", 0, mem_l15_req_ack);
        reset_err = errors;
        $display("test %-8s %s", "reset", (reset_err == 0) ? "ok" : "FAILED");

        for (int i = 0; i < NROWS; i++) begin
            mem_op = ops[i];
            op_a = bases[i];
            op_b = opnds[i];
            s_imm = imms[i];
            if (kinds[i] == 0) begin
                pending.push_back(i);
                access_cnt++;
            end
            hold_until_taken();
            mem_op = '0;
            if (kinds[i] != 0) begin
                for (c = 0; c < ROW_CYC && !(ld_misaligned || st_misaligned); c++) begin
                    @(negedge clk);
                end
                assert (c < ROW_CYC) else begin
                    $display("%s: misalignment flag was never raised", names[i]);
                    note_error(i);
                end
                check_value(i, "ld_misaligned", kinds[i] == 1, ld_misaligned);
                check_value(i, "st_misaligned", kinds[i] == 2, st_misaligned);
                check_value(i, "mem_l15_val", 0, mem_l15_val);
                $display("test %-8s %s", names[i], (row_err[i] == 0) ? "ok" : "FAILED");
            end
        end
        while (done_cnt < access_cnt) @(negedge clk);
        repeat (4) @(negedge clk);     // lets the bound checks see the tail

        passed = (reset_err == 0) ? 1 : 0;
        for (int i = 0; i < NROWS; i++) if (row_err[i] == 0) passed++;
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NROWS + 1, passed, NROWS + 1 - passed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/mem_pkg.sv
design/mem_stage_reg.sv
design/mem_addr_gen.sv
design/l15_req_ctrl.sv
design/load_align.sv
design/mem_wrap.sv
tb/mem_wrap_assert.sv
tb/mem_wrap_tb.sv
